//--- hdl/vga_pkg.sv
package vga_pkg;

    // 640x480 at one pixel per clock
    localparam int H_DISP  = 640;
    localparam int H_FRONT = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BACK  = 48;
    localparam int H_TOTAL = 800;

    localparam int V_DISP  = 480;
    localparam int V_FRONT = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BACK  = 33;
    localparam int V_TOTAL = 525;

    localparam int CNT_W = 10;

    // Tile image size after halving the screen position
    localparam int TILE_W   = 80;
    localparam int TILE_H   = 60;
    localparam int GRID_DIM = 4;

    // ROM address is {row, column}
    localparam int IMG_X_W    = 7;
    localparam int IMG_Y_W    = 6;
    localparam int ROM_ADDR_W = 13;

    localparam int RGB_W = 12;
    localparam int CH_W  = 4;

endpackage

//--- hdl/game_pkg.sv
package game_pkg;

    localparam int N_TILES    = 16;
    localparam int N_IMAGES   = 8;
    localparam int WIN_PAIRS  = 8;
    localparam int TILE_IDX_W = 4;
    localparam int IMG_IDX_W  = 3;
    localparam int PAIR_CNT_W = 4;

    // Tiles 0, 2 and 3 start upside down
    localparam logic [N_TILES-1:0] INIT_FLIP = 16'h000D;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_SHOW,
        ST_GAME,
        ST_FINISH
    } game_state_t;

    localparam int SC_W = 9;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V in tile order
    localparam logic [SC_W-1:0] SC_TILE [N_TILES] = '{
        9'h016, 9'h01E, 9'h026, 9'h025,
        9'h015, 9'h01D, 9'h024, 9'h02D,
        9'h01C, 9'h01B, 9'h023, 9'h02B,
        9'h01A, 9'h022, 9'h021, 9'h02A
    };
    localparam logic [SC_W-1:0] SC_SHIFT = 9'h012;
    localparam logic [SC_W-1:0] SC_ENTER = 9'h05A;

    localparam int DEB_LEN = 7;

endpackage

//--- hdl/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic press_o
);
    import game_pkg::*;

    logic [DEB_LEN-1:0] samples;
    logic               held;
    logic               held_d;

    // Held only after DEB_LEN high samples in a row
    assign held = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            held_d  <= 1'b0;
            press_o <= 1'b0;
        end else begin
            samples <= {samples[DEB_LEN-2:0], btn_i};
            held_d  <= held;
            // Rising edge of the held level
            press_o <= held & ~held_d;
        end
    end

endmodule

//--- hdl/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
    input  logic                      clk,
    input  logic                      rst,
    output logic [vga_pkg::CNT_W-1:0] h_cnt_o,
    output logic [vga_pkg::CNT_W-1:0] v_cnt_o,
    output logic                      visible_o,
    output logic                      hsync_o,
    output logic                      vsync_o
);
    import vga_pkg::*;

    logic h_last;

    assign h_last = (h_cnt_o == CNT_W'(H_TOTAL - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt_o <= '0;
            v_cnt_o <= '0;
        end else begin
            if (h_last) begin
                h_cnt_o <= '0;
                if (v_cnt_o == CNT_W'(V_TOTAL - 1)) begin
                    v_cnt_o <= '0;
                end else begin
                    v_cnt_o <= v_cnt_o + 1'b1;
                end
            end else begin
                h_cnt_o <= h_cnt_o + 1'b1;
            end
        end
    end

    // Compare against value minus one since the syncs are registered
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            hsync_o <= !((h_cnt_o >= CNT_W'(H_DISP + H_FRONT - 1)) &&
                         (h_cnt_o <  CNT_W'(H_DISP + H_FRONT + H_SYNC - 1)));
            vsync_o <= !((v_cnt_o >= CNT_W'(V_DISP + V_FRONT - 1)) &&
                         (v_cnt_o <  CNT_W'(V_DISP + V_FRONT + V_SYNC - 1)));
        end
    end

    assign visible_o = (h_cnt_o < CNT_W'(H_DISP)) && (v_cnt_o < CNT_W'(V_DISP));

endmodule

//--- hdl/tile_fetch.sv
`timescale 1ns/1ns

module tile_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [vga_pkg::CNT_W-1:0]    h_cnt_i,
    input  logic [vga_pkg::CNT_W-1:0]    v_cnt_i,
    input  logic                         visible_i,
    input  logic                         hsync_i,
    input  logic                         vsync_i,
    input  logic [game_pkg::N_TILES-1:0] show_mask_i,
    input  logic [game_pkg::N_TILES-1:0] flip_mask_i,
    output logic [vga_pkg::RGB_W-1:0]    rgb_o,
    output logic                         hsync_o,
    output logic                         vsync_o
);
    import vga_pkg::*;
    import game_pkg::*;

    logic [CNT_W-1:0]      x_half;
    logic [CNT_W-1:0]      y_half;
    logic [CNT_W-1:0]      grid_col;
    logic [CNT_W-1:0]      grid_row;
    logic [CNT_W-1:0]      y_in_tile;
    logic [TILE_IDX_W-1:0] tile_idx;
    logic [IMG_IDX_W-1:0]  img_idx;
    logic [IMG_X_W-1:0]    img_x;
    logic [IMG_Y_W-1:0]    img_y;
    logic [ROM_ADDR_W-1:0] rom_addr;
    logic                  pixel_on;

    // Image ROM word is marker bit, image number, row and top two column bits
    function automatic logic [RGB_W-1:0] image_rom(input logic [IMG_IDX_W-1:0]  img,
                                                   input logic [ROM_ADDR_W-1:0] addr);
        return {1'b1, img, addr[ROM_ADDR_W-1 -: IMG_Y_W], addr[IMG_X_W-1 -: 2]};
    endfunction

    always_comb begin
        x_half    = h_cnt_i >> 1;
        y_half    = v_cnt_i >> 1;
        grid_col  = x_half / CNT_W'(TILE_W);
        grid_row  = y_half / CNT_W'(TILE_H);
        tile_idx  = TILE_IDX_W'(grid_row * CNT_W'(GRID_DIM) + grid_col);
        img_idx   = IMG_IDX_W'(tile_idx % TILE_IDX_W'(N_IMAGES));
        img_x     = IMG_X_W'(x_half % CNT_W'(TILE_W));
        y_in_tile = y_half % CNT_W'(TILE_H);
        // Upside-down tiles read their rows bottom first
        if (flip_mask_i[tile_idx]) begin
            img_y = IMG_Y_W'(CNT_W'(TILE_H - 1) - y_in_tile);
        end else begin
            img_y = IMG_Y_W'(y_in_tile);
        end
        rom_addr = {img_y, img_x};
        pixel_on = visible_i && show_mask_i[tile_idx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o   <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            rgb_o   <= pixel_on ? image_rom(img_idx, rom_addr) : '0;
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
        end
    end

endmodule

//--- hdl/key_decoder.sv
`timescale 1ns/1ns

module key_decoder (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            key_stb_i,
    input  logic [game_pkg::SC_W-1:0]       key_code_i,
    output logic                            pair_stb_o,
    output logic                            flip_stb_o,
    output logic                            conceal_stb_o,
    output logic [game_pkg::TILE_IDX_W-1:0] tile_a_o,
    output logic [game_pkg::TILE_IDX_W-1:0] tile_b_o
);
    import game_pkg::*;

    logic                  tile_hit;
    logic [TILE_IDX_W-1:0] tile_hit_idx;
    logic                  pend_tile_vld;
    logic                  pend_shift;
    logic [TILE_IDX_W-1:0] pend_tile;

    always_comb begin
        tile_hit     = 1'b0;
        tile_hit_idx = '0;
        for (int i = 0; i < N_TILES; i++) begin
            if (key_code_i == SC_TILE[i]) begin
                tile_hit     = 1'b1;
                tile_hit_idx = TILE_IDX_W'(i);
            end
        end
    end

    // Pending tile and pending shift are never set together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pair_stb_o    <= 1'b0;
            flip_stb_o    <= 1'b0;
            conceal_stb_o <= 1'b0;
            pend_tile_vld <= 1'b0;
            pend_shift    <= 1'b0;
        end else begin
            pair_stb_o    <= 1'b0;
            flip_stb_o    <= 1'b0;
            conceal_stb_o <= 1'b0;
            if (key_stb_i) begin
                if (tile_hit) begin
                    if (pend_shift) begin
                        flip_stb_o <= 1'b1;
                        pend_shift <= 1'b0;
                    end else if (pend_tile_vld) begin
                        pair_stb_o    <= 1'b1;
                        pend_tile_vld <= 1'b0;
                    end else begin
                        pend_tile_vld <= 1'b1;
                    end
                end else if (key_code_i == SC_SHIFT) begin
                    pend_shift    <= 1'b1;
                    pend_tile_vld <= 1'b0;
                end else if (key_code_i == SC_ENTER) begin
                    conceal_stb_o <= 1'b1;
                    pend_shift    <= 1'b0;
                    pend_tile_vld <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_stb_i && tile_hit) begin
            pend_tile <= tile_hit_idx;
            if (pend_tile_vld && !pend_shift) begin
                tile_a_o <= pend_tile;
                tile_b_o <= tile_hit_idx;
            end else begin
                tile_a_o <= tile_hit_idx;
            end
        end
    end

endmodule

//--- hdl/match_board.sv
`timescale 1ns/1ns

module match_board (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_i,
    input  logic                            hint_i,
    input  logic                            pair_stb_i,
    input  logic                            flip_stb_i,
    input  logic                            conceal_stb_i,
    input  logic [game_pkg::TILE_IDX_W-1:0] tile_a_i,
    input  logic [game_pkg::TILE_IDX_W-1:0] tile_b_i,
    output logic [game_pkg::N_TILES-1:0]    show_mask_o,
    output logic [game_pkg::N_TILES-1:0]    flip_mask_o,
    output logic                            pass_o
);
    import game_pkg::*;

    game_state_t           state;
    logic [N_TILES-1:0]    match_mask;
    logic [PAIR_CNT_W-1:0] pair_cnt;
    logic [IMG_IDX_W-1:0]  img_a;
    logic [IMG_IDX_W-1:0]  img_b;
    logic                  pair_ok;

    // Two different unmatched tiles with the same image and orientation
    always_comb begin
        img_a   = IMG_IDX_W'(tile_a_i % TILE_IDX_W'(N_IMAGES));
        img_b   = IMG_IDX_W'(tile_b_i % TILE_IDX_W'(N_IMAGES));
        pair_ok = (tile_a_i != tile_b_i) && (img_a == img_b) &&
                  (flip_mask_o[tile_a_i] == flip_mask_o[tile_b_i]) &&
                  !match_mask[tile_a_i] && !match_mask[tile_b_i];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ST_INIT;
            show_mask_o <= '0;
            match_mask  <= '0;
            flip_mask_o <= INIT_FLIP;
            pair_cnt    <= '0;
            pass_o      <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    if (start_i) begin
                        state       <= ST_SHOW;
                        show_mask_o <= '1;
                        match_mask  <= '0;
                        flip_mask_o <= INIT_FLIP;
                        pair_cnt    <= '0;
                    end
                end
                ST_SHOW: begin
                    if (start_i) begin
                        state <= ST_GAME;
                    end
                end
                ST_GAME: begin
                    if (pair_cnt == PAIR_CNT_W'(WIN_PAIRS)) begin
                        state       <= ST_FINISH;
                        show_mask_o <= '1;
                        pass_o      <= 1'b1;
                    end else if (hint_i) begin
                        show_mask_o <= '1;
                    end else if (pair_stb_i) begin
                        show_mask_o[tile_a_i] <= 1'b1;
                        show_mask_o[tile_b_i] <= 1'b1;
                        if (pair_ok) begin
                            match_mask[tile_a_i] <= 1'b1;
                            match_mask[tile_b_i] <= 1'b1;
                            pair_cnt             <= pair_cnt + 1'b1;
                        end
                    end else if (flip_stb_i) begin
                        flip_mask_o[tile_a_i] <= ~flip_mask_o[tile_a_i];
                        show_mask_o[tile_a_i] <= 1'b1;
                    end else if (conceal_stb_i) begin
                        show_mask_o <= match_mask;
                    end
                end
                default: begin
                    // Finished board stays up until reset
                    show_mask_o <= '1;
                    pass_o      <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- hdl/memory_game_top.sv
`timescale 1ns/1ns

module memory_game_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      hint_i,
    input  logic                      key_stb_i,
    input  logic [game_pkg::SC_W-1:0] key_code_i,
    output logic                      hsync_o,
    output logic                      vsync_o,
    output logic [vga_pkg::CH_W-1:0]  red_o,
    output logic [vga_pkg::CH_W-1:0]  green_o,
    output logic [vga_pkg::CH_W-1:0]  blue_o,
    output logic                      pass_o
);
    import vga_pkg::*;
    import game_pkg::*;

    logic                  start_pulse;
    logic                  hint_pulse;
    logic [CNT_W-1:0]      h_cnt;
    logic [CNT_W-1:0]      v_cnt;
    logic                  visible;
    logic                  hsync_raw;
    logic                  vsync_raw;
    logic [RGB_W-1:0]      rgb;
    logic                  pair_stb;
    logic                  flip_stb;
    logic                  conceal_stb;
    logic [TILE_IDX_W-1:0] tile_a;
    logic [TILE_IDX_W-1:0] tile_b;
    logic [N_TILES-1:0]    show_mask;
    logic [N_TILES-1:0]    flip_mask;

    button_conditioner i_start_cond (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (start_i),
        .press_o (start_pulse)
    );

    button_conditioner i_hint_cond (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (hint_i),
        .press_o (hint_pulse)
    );

    vga_timing i_vga_timing (
        .clk       (clk),
        .rst       (rst),
        .h_cnt_o   (h_cnt),
        .v_cnt_o   (v_cnt),
        .visible_o (visible),
        .hsync_o   (hsync_raw),
        .vsync_o   (vsync_raw)
    );

    tile_fetch i_tile_fetch (
        .clk         (clk),
        .rst         (rst),
        .h_cnt_i     (h_cnt),
        .v_cnt_i     (v_cnt),
        .visible_i   (visible),
        .hsync_i     (hsync_raw),
        .vsync_i     (vsync_raw),
        .show_mask_i (show_mask),
        .flip_mask_i (flip_mask),
        .rgb_o       (rgb),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o)
    );

    key_decoder i_key_decoder (
        .clk           (clk),
        .rst           (rst),
        .key_stb_i     (key_stb_i),
        .key_code_i    (key_code_i),
        .pair_stb_o    (pair_stb),
        .flip_stb_o    (flip_stb),
        .conceal_stb_o (conceal_stb),
        .tile_a_o      (tile_a),
        .tile_b_o      (tile_b)
    );

    match_board i_match_board (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_pulse),
        .hint_i        (hint_pulse),
        .pair_stb_i    (pair_stb),
        .flip_stb_i    (flip_stb),
        .conceal_stb_i (conceal_stb),
        .tile_a_i      (tile_a),
        .tile_b_i      (tile_b),
        .show_mask_o   (show_mask),
        .flip_mask_o   (flip_mask),
        .pass_o        (pass_o)
    );

    assign {red_o, green_o, blue_o} = rgb;

endmodule

//--- sim/memory_game_sva.sv
`timescale 1ns/1ns

module memory_game_sva (
    input logic                      clk,
    input logic                      rst,
    input logic [vga_pkg::CNT_W-1:0] h_cnt_i,
    input logic                      hsync_i,
    input logic                      vsync_i
);
    import vga_pkg::*;

    logic [CNT_W-1:0] low_cnt;

    // Length of the current hsync pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            low_cnt <= '0;
        end else if (!hsync_i) begin
            low_cnt <= low_cnt + 1'b1;
        end else begin
            low_cnt <= '0;
        end
    end

    hsync_width_a: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync_i) |-> low_cnt == CNT_W'(H_SYNC))
        else $error("hsync pulse shorter than H_SYNC");

    hsync_max_a: assert property (@(posedge clk) disable iff (rst)
        !hsync_i |-> low_cnt < CNT_W'(H_SYNC))
        else $error("hsync pulse longer than H_SYNC");

    // Registered vsync follows the line counter one pixel late
    vsync_line_a: assert property (@(posedge clk) disable iff (rst)
        $changed(vsync_i) |-> h_cnt_i == CNT_W'(1))
        else $error("vsync changed away from a line start");

endmodule

bind vga_timing memory_game_sva i_vga_sva (
    .clk     (clk),
    .rst     (rst),
    .h_cnt_i (h_cnt_o),
    .hsync_i (hsync_o),
    .vsync_i (vsync_o)
);

//--- sim/tb_memory_game.sv
`timescale 1ns/1ns

module tb_memory_game;
    import vga_pkg::*;
    import game_pkg::*;

    // Sequence spans eleven frames plus one spare frame
    localparam int N_FRAMES       = 11;
    localparam int TIMEOUT_CYCLES = (N_FRAMES + 1) * H_TOTAL * V_TOTAL;
    localparam logic [SC_W-1:0] SC_UNKNOWN = 9'h076;

    logic            clk;
    logic            rst;
    logic            start_i;
    logic            hint_i;
    logic            key_stb_i;
    logic [SC_W-1:0] key_code_i;
    logic            hsync_o;
    logic            vsync_o;
    logic [CH_W-1:0] red_o;
    logic [CH_W-1:0] green_o;
    logic [CH_W-1:0] blue_o;
    logic            pass_o;

    // Reference model of the display pipeline
    logic [CNT_W-1:0] m_h;
    logic [CNT_W-1:0] m_v;
    logic             m_hs_raw;
    logic             m_vs_raw;
    logic             m_hs;
    logic             m_vs;
    logic [RGB_W-1:0] m_rgb;

    // Reference model of the game
    game_state_t           m_state;
    logic [N_TILES-1:0]    m_show;
    logic [N_TILES-1:0]    m_flip;
    logic [N_TILES-1:0]    m_match;
    int                    m_pairs;
    logic                  m_pass;
    logic                  pend_vld;
    logic                  pend_shift;
    logic [TILE_IDX_W-1:0] pend_t;

    logic [31:0] lfsr;
    int          cycle_cnt;

    memory_game_top i_memory_game_top (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .hint_i     (hint_i),
        .key_stb_i  (key_stb_i),
        .key_code_i (key_code_i),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .red_o      (red_o),
        .green_o    (green_o),
        .blue_o     (blue_o),
        .pass_o     (pass_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hB4BCD35C;
        end
        return s >> 1;
    endfunction

    // Marker bit, image, image row, top two column bits
    function automatic logic [RGB_W-1:0] pixel_colour(input int h, input int v,
                                                      input logic [N_TILES-1:0] show,
                                                      input logic [N_TILES-1:0] flip);
        int x;
        int y;
        int t;
        int row;
        int col;
        if (h >= H_DISP || v >= V_DISP) begin
            return '0;
        end
        x = h / 2;
        y = v / 2;
        t = (y / TILE_H) * GRID_DIM + x / TILE_W;
        if (!show[t]) begin
            return '0;
        end
        row = y % TILE_H;
        col = x % TILE_W;
        if (flip[t]) begin
            row = TILE_H - 1 - row;
        end
        return {1'b1, 3'(t % N_IMAGES), 6'(row), 2'(col >> 5)};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_h      <= '0;
            m_v      <= '0;
            m_hs_raw <= 1'b1;
            m_vs_raw <= 1'b1;
            m_hs     <= 1'b1;
            m_vs     <= 1'b1;
            m_rgb    <= '0;
        end else begin
            if (m_h == CNT_W'(H_TOTAL - 1)) begin
                m_h <= '0;
                m_v <= (m_v == CNT_W'(V_TOTAL - 1)) ? '0 : m_v + 1'b1;
            end else begin
                m_h <= m_h + 1'b1;
            end
            m_hs_raw <= !(m_h >= CNT_W'(H_DISP + H_FRONT - 1) &&
                          m_h <  CNT_W'(H_DISP + H_FRONT + H_SYNC - 1));
            m_vs_raw <= !(m_v >= CNT_W'(V_DISP + V_FRONT - 1) &&
                          m_v <  CNT_W'(V_DISP + V_FRONT + V_SYNC - 1));
            m_hs     <= m_hs_raw;
            m_vs     <= m_vs_raw;
            m_rgb    <= pixel_colour(m_h, m_v, m_show, m_flip);
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        check_value("hsync_o", hsync_o, m_hs);
        check_value("vsync_o", vsync_o, m_vs);
        check_value("pixel colour", {red_o, green_o, blue_o}, m_rgb);
        check_value("pass_o", pass_o, m_pass);
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic take_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    task automatic wait_blank();
        do begin
            @(posedge clk);
        end while (!(m_v == CNT_W'(V_DISP) && m_h == '0));
    endtask

    task automatic board_pair(input int a, input int b);
        m_show[a] = 1'b1;
        m_show[b] = 1'b1;
        if (a != b && a % N_IMAGES == b % N_IMAGES && m_flip[a] == m_flip[b] &&
            !m_match[a] && !m_match[b]) begin
            m_match[a] = 1'b1;
            m_match[b] = 1'b1;
            m_pairs++;
            if (m_pairs == WIN_PAIRS) begin
                m_state = ST_FINISH;
                m_show  = '1;
                m_pass  = 1'b1;
            end
        end
    endtask

    task automatic apply_key(input logic [SC_W-1:0] code);
        int t;
        t = -1;
        for (int i = 0; i < N_TILES; i++) begin
            if (code == SC_TILE[i]) begin
                t = i;
            end
        end
        if (t >= 0) begin
            if (pend_shift) begin
                pend_shift = 1'b0;
                if (m_state == ST_GAME) begin
                    m_flip[t] = ~m_flip[t];
                    m_show[t] = 1'b1;
                end
            end else if (pend_vld) begin
                pend_vld = 1'b0;
                if (m_state == ST_GAME) begin
                    board_pair(pend_t, t);
                end
            end else begin
                pend_vld = 1'b1;
                pend_t   = TILE_IDX_W'(t);
            end
        end else if (code == SC_SHIFT) begin
            pend_shift = 1'b1;
            pend_vld   = 1'b0;
        end else if (code == SC_ENTER) begin
            pend_shift = 1'b0;
            pend_vld   = 1'b0;
            if (m_state == ST_GAME) begin
                m_show = m_match;
            end
        end
    endtask

    // Strobe, decode, board update, then the model follows
    task automatic send_key(input logic [SC_W-1:0] code);
        @(posedge clk);
        key_stb_i  <= 1'b1;
        key_code_i <= code;
        @(posedge clk);
        key_stb_i <= 1'b0;
        repeat (2) @(posedge clk);
        apply_key(code);
    endtask

    task automatic press_button(input logic hint);
        @(posedge clk);
        if (hint) begin
            hint_i <= 1'b1;
        end else begin
            start_i <= 1'b1;
        end
        repeat (10) @(posedge clk);
        start_i <= 1'b0;
        hint_i  <= 1'b0;
        repeat (20) @(posedge clk);
        if (hint && m_state == ST_GAME) begin
            m_show = '1;
        end else if (!hint && m_state == ST_INIT) begin
            m_state = ST_SHOW;
            m_show  = '1;
            m_match = '0;
            m_flip  = INIT_FLIP;
            m_pairs = 0;
        end else if (!hint && m_state == ST_SHOW) begin
            m_state = ST_GAME;
        end
    endtask

    task automatic random_key();
        logic [7:0] kind;
        logic [7:0] tile;
        take_bits(2, kind);
        if (kind < 2) begin
            take_bits(4, tile);
            send_key(SC_TILE[tile[3:0]]);
        end else if (kind == 2) begin
            send_key(SC_SHIFT);
        end else begin
            send_key(SC_ENTER);
        end
    endtask

    task automatic win_game();
        for (int t = 0; t < N_TILES; t++) begin
            if (m_flip[t] && !m_match[t]) begin
                send_key(SC_SHIFT);
                send_key(SC_TILE[t]);
            end
        end
        for (int p = 0; p < N_IMAGES; p++) begin
            send_key(SC_TILE[p]);
            send_key(SC_TILE[p + N_IMAGES]);
        end
        @(negedge clk);
        check_value("pass_o after the eighth pair", pass_o, 1);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start_i    = 1'b0;
        hint_i     = 1'b0;
        key_stb_i  = 1'b0;
        key_code_i = '0;
        m_state    = ST_INIT;
        m_show     = '0;
        m_flip     = INIT_FLIP;
        m_match    = '0;
        m_pairs    = 0;
        m_pass     = 1'b0;
        pend_vld   = 1'b0;
        pend_shift = 1'b0;
        pend_t     = '0;
        lfsr       = 32;
        cycle_cnt  = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Frame 0 is blank, frame 1 shows the board
        wait_blank();
        press_button(1'b0);
        wait_blank();
        press_button(1'b0);
        random_key();
        repeat (4) begin
            wait_blank();
            random_key();
        end
        wait_blank();
        send_key(SC_UNKNOWN);
        wait_blank();
        press_button(1'b1);
        wait_blank();
        send_key(SC_ENTER);
        wait_blank();
        win_game();
        wait_blank();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- vlog.f
hdl/vga_pkg.sv
hdl/game_pkg.sv
hdl/button_conditioner.sv
hdl/vga_timing.sv
hdl/tile_fetch.sv
hdl/key_decoder.sv
hdl/match_board.sv
hdl/memory_game_top.sv
sim/memory_game_sva.sv
sim/tb_memory_game.sv

//--- Makefile
TOP = tb_memory_game
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
